/* nx_defs.svh */
////////////////////////////////////////
// Mesh node router widths
// Stream, position and payload sizing shared by the router blocks
////////////////////////////////////////

`ifndef NX_DEFS_SVH
`define NX_DEFS_SVH

// Full message width on every stream
`define NX_STREAM_WIDTH 32

// Width of one row or column index in the mesh
`define NX_ADDR_WIDTH 4

// Payload bits left after row, column and command
// 32 = 4 + 4 + 2 + 22
`define NX_PAYLOAD_WIDTH 22

// Entries held by each inbound skid buffer
`define NX_SKID_DEPTH 2

`endif

/* nx_pkg.sv */
////////////////////////////////////////
// Mesh node router types
// Directions, opcodes, skid occupancy and the message layout
////////////////////////////////////////

`include "nx_defs.svh"

package nx_pkg;

    // Neighbour directions, clockwise order from north
    typedef enum logic [1:0] {
        DIRX_NORTH = 2'd0,
        DIRX_EAST  = 2'd1,
        DIRX_SOUTH = 2'd2,
        DIRX_WEST  = 2'd3
    } nx_dir_t;

    // Message opcode
    // Carried through the router untouched
    typedef enum logic [1:0] {
        NX_CMD_LOAD   = 2'd0,
        NX_CMD_STORE  = 2'd1,
        NX_CMD_SIGNAL = 2'd2,
        NX_CMD_OUTPUT = 2'd3
    } nx_cmd_t;

    // Skid buffer occupancy
    typedef enum logic [1:0] {
        SKID_EMPTY = 2'd0,
        SKID_ONE   = 2'd1,
        SKID_FULL  = 2'd2
    } nx_skid_state_t;

    // Message as carried on every stream, MSB first
    // Target position sits at the top of the word
    typedef struct packed {
        logic [`NX_ADDR_WIDTH-1:0]    tgt_row;
        logic [`NX_ADDR_WIDTH-1:0]    tgt_col;
        nx_cmd_t                      command;
        logic [`NX_PAYLOAD_WIDTH-1:0] payload;
    } nx_msg_t;

endpackage : nx_pkg

/* nx_stream_skid.sv */
////////////////////////////////////////
// Inbound stream skid buffer
// Two registered entries between a neighbour and the routing path
////////////////////////////////////////

`timescale 1ns/1ps

`include "nx_defs.svh"

module nx_stream_skid (
    input  logic            clk_i,
    input  logic            rst_i,
    // Inbound neighbour stream
    input  nx_pkg::nx_msg_t in_msg_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    // Buffered stream towards the arbiter
    output nx_pkg::nx_msg_t out_msg_o,
    output logic            out_valid_o,
    input  logic            out_ready_i
);

    import nx_pkg::*;

    // Entry 0 always holds the oldest message
    logic [`NX_STREAM_WIDTH-1:0] mem_q [`NX_SKID_DEPTH];
    nx_skid_state_t              state_q;
    nx_skid_state_t              state_d;
    logic                        push;
    logic                        pop;

    // Room while fewer than two entries held
    assign in_ready_o  = (state_q != SKID_FULL);
    assign out_valid_o = (state_q != SKID_EMPTY);
    assign out_msg_o   = nx_msg_t'(mem_q[0]);

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    // Occupancy FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            SKID_EMPTY: if (push) state_d = SKID_ONE;
            // Push and pop together keep one entry
            SKID_ONE: begin
                if (push && !pop) begin
                    state_d = SKID_FULL;
                end else if (pop && !push) begin
                    state_d = SKID_EMPTY;
                end
            end
            SKID_FULL: if (pop) state_d = SKID_ONE;
            default: state_d = SKID_EMPTY;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= SKID_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        case (state_q)
            SKID_EMPTY: begin
                if (push) begin
                    mem_q[0] <= in_msg_i;
                end
            end
            SKID_ONE: begin
                // Head replaced when it leaves in the same cycle
                if (push && pop) begin
                    mem_q[0] <= in_msg_i;
                end else if (push) begin
                    mem_q[`NX_SKID_DEPTH-1] <= in_msg_i;
                end
            end
            SKID_FULL: begin
                // Second entry moves up to the head
                if (pop) begin
                    mem_q[0] <= mem_q[`NX_SKID_DEPTH-1];
                end
            end
            default: ;
        endcase
    end

endmodule : nx_stream_skid

/* nx_stream_arbiter.sv */
////////////////////////////////////////
// Round-robin stream arbiter
// Picks one of four buffered inbound streams per transfer
////////////////////////////////////////

`timescale 1ns/1ps

module nx_stream_arbiter (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Buffered requesters, indexed by direction
    input  nx_pkg::nx_msg_t [3:0] req_msg_i,
    input  logic [3:0]            req_valid_i,
    output logic [3:0]            req_ready_o,
    // Granted stream towards the decoder
    output nx_pkg::nx_msg_t       grant_msg_o,
    output logic                  grant_valid_o,
    input  logic                  grant_ready_i
);

    import nx_pkg::*;

    // Last winner pointer, lock flag and locked requester
    logic [1:0] last_q;
    logic       lock_q;
    logic [1:0] lock_idx_q;

    logic [1:0] rr_idx;
    logic       rr_found;
    logic       use_lock;
    logic [1:0] sel_idx;
    logic       accept;

    // Search starts one past the last winner
    always_comb begin
        logic [1:0] cand;
        rr_found = 1'b0;
        rr_idx   = last_q;
        for (int k = 1; k < 5; k++) begin
            cand = last_q + 2'(k);
            if (!rr_found && req_valid_i[cand]) begin
                rr_found = 1'b1;
                rr_idx   = cand;
            end
        end
    end

    // Locked grant only counts while that buffer still offers data
    assign use_lock = lock_q && req_valid_i[lock_idx_q];
    assign sel_idx  = use_lock ? lock_idx_q : rr_idx;

    // Data path stays combinational
    assign grant_valid_o = use_lock || rr_found;
    assign grant_msg_o   = req_msg_i[sel_idx];
    assign accept        = grant_valid_o && grant_ready_i;

    // Ready back to the granted buffer alone
    always_comb begin
        req_ready_o = '0;
        if (grant_valid_o) begin
            req_ready_o[sel_idx] = grant_ready_i;
        end
    end

    // West as last winner puts north first after reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q     <= DIRX_WEST;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else if (accept) begin
            // Advance past the winner and release
            last_q <= sel_idx;
            lock_q <= 1'b0;
        end else if (grant_valid_o) begin
            // Stalled, hold this requester
            lock_q     <= 1'b1;
            lock_idx_q <= sel_idx;
        end else begin
            lock_q <= 1'b0;
        end
    end

endmodule : nx_stream_arbiter

/* nx_msg_decoder.sv */
////////////////////////////////////////
// Message decoder
// Local delivery or row-first steering towards a neighbour
////////////////////////////////////////

`timescale 1ns/1ps

`include "nx_defs.svh"

module nx_msg_decoder (
    // Position of this node in the mesh
    input  logic [`NX_ADDR_WIDTH-1:0] node_row_i,
    input  logic [`NX_ADDR_WIDTH-1:0] node_col_i,
    // Granted message from the arbiter
    input  nx_pkg::nx_msg_t           msg_i,
    input  logic                      msg_valid_i,
    output logic                      msg_ready_o,
    // Local delivery stream
    output nx_pkg::nx_msg_t           local_msg_o,
    output logic                      local_valid_o,
    input  logic                      local_ready_i,
    // Tagged stream towards the distributor
    output nx_pkg::nx_msg_t           dist_msg_o,
    output nx_pkg::nx_dir_t           dist_dir_o,
    output logic                      dist_valid_o,
    input  logic                      dist_ready_i
);

    import nx_pkg::*;

    logic row_lt;
    logic row_gt;
    logic col_lt;
    logic col_gt;
    logic is_local;

    // Target against own position
    assign row_lt = (msg_i.tgt_row < node_row_i);
    assign row_gt = (msg_i.tgt_row > node_row_i);
    assign col_lt = (msg_i.tgt_col < node_col_i);
    assign col_gt = (msg_i.tgt_col > node_col_i);

    // Arrived when both indices match
    assign is_local = !row_lt && !row_gt && !col_lt && !col_gt;

    // Row first, then column
    // Lower rows lie north, lower columns lie west
    always_comb begin
        if (row_lt) begin
            dist_dir_o = DIRX_NORTH;
        end else if (row_gt) begin
            dist_dir_o = DIRX_SOUTH;
        end else if (col_lt) begin
            dist_dir_o = DIRX_WEST;
        end else begin
            // Also taken for local messages, valid stays low then
            dist_dir_o = DIRX_EAST;
        end
    end

    // Same message on both sides
    assign local_msg_o = msg_i;
    assign dist_msg_o  = msg_i;

    // Only one side sees valid
    assign local_valid_o = msg_valid_i && is_local;
    assign dist_valid_o  = msg_valid_i && !is_local;

    // Ready from whichever side owns this message
    assign msg_ready_o = is_local ? local_ready_i : dist_ready_i;

endmodule : nx_msg_decoder

/* nx_stream_distributor.sv */
////////////////////////////////////////
// Stream distributor
// Tagged message out to one neighbour, deflected clockwise if absent
////////////////////////////////////////

`timescale 1ns/1ps

module nx_stream_distributor (
    input  logic            clk_i,
    input  logic            rst_i,
    // Tagged inbound stream
    input  nx_pkg::nx_msg_t dist_data_i,
    input  nx_pkg::nx_dir_t dist_dir_i,
    input  logic            dist_valid_i,
    output logic            dist_ready_o,
    // North
    output nx_pkg::nx_msg_t north_data_o,
    output logic            north_valid_o,
    input  logic            north_ready_i,
    input  logic            north_present_i,
    // East
    output nx_pkg::nx_msg_t east_data_o,
    output logic            east_valid_o,
    input  logic            east_ready_i,
    input  logic            east_present_i,
    // South
    output nx_pkg::nx_msg_t south_data_o,
    output logic            south_valid_o,
    input  logic            south_ready_i,
    input  logic            south_present_i,
    // West
    output nx_pkg::nx_msg_t west_data_o,
    output logic            west_valid_o,
    input  logic            west_ready_i,
    input  logic            west_present_i
);

    import nx_pkg::*;

    // Neighbour levels gathered, bit index is the direction
    logic [3:0] present_vec;
    logic [3:0] ready_vec;
    logic [3:0] valid_vec;
    nx_dir_t    pick_dir;
    nx_dir_t    route_dir;
    // Chosen port pinned while a message waits
    logic       lock_q;
    nx_dir_t    lock_dir_q;

    assign present_vec = {west_present_i, south_present_i, east_present_i, north_present_i};
    assign ready_vec   = {west_ready_i, south_ready_i, east_ready_i, north_ready_i};

    // Requested port, or the next one clockwise when absent
    assign pick_dir = present_vec[dist_dir_i] ? dist_dir_i : nx_dir_t'(dist_dir_i + 2'd1);

    // A presence change must not move a pending valid
    assign route_dir = lock_q ? lock_dir_q : pick_dir;

    always_comb begin
        valid_vec            = '0;
        valid_vec[route_dir] = dist_valid_i;
    end

    // Data fans out, only the chosen valid rises
    assign north_data_o  = dist_data_i;
    assign east_data_o   = dist_data_i;
    assign south_data_o  = dist_data_i;
    assign west_data_o   = dist_data_i;
    assign north_valid_o = valid_vec[DIRX_NORTH];
    assign east_valid_o  = valid_vec[DIRX_EAST];
    assign south_valid_o = valid_vec[DIRX_SOUTH];
    assign west_valid_o  = valid_vec[DIRX_WEST];

    assign dist_ready_o = ready_vec[route_dir];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lock_q     <= 1'b0;
            lock_dir_q <= DIRX_NORTH;
        end else if (dist_valid_i && !dist_ready_o) begin
            lock_q     <= 1'b1;
            lock_dir_q <= route_dir;
        end else begin
            // Released on transfer or when idle
            lock_q <= 1'b0;
        end
    end

endmodule : nx_stream_distributor

/* nx_node_router.sv */
////////////////////////////////////////
// Mesh node router
// Skid buffers, arbiter, decoder and distributor for one node
////////////////////////////////////////

`timescale 1ns/1ps

`include "nx_defs.svh"

module nx_node_router (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Own mesh position
    input  logic [`NX_ADDR_WIDTH-1:0] node_row_i,
    input  logic [`NX_ADDR_WIDTH-1:0] node_col_i,
    // North
    input  nx_pkg::nx_msg_t           north_in_msg_i,
    input  logic                      north_in_valid_i,
    output logic                      north_in_ready_o,
    output nx_pkg::nx_msg_t           north_out_msg_o,
    output logic                      north_out_valid_o,
    input  logic                      north_out_ready_i,
    input  logic                      north_out_present_i,
    // East
    input  nx_pkg::nx_msg_t           east_in_msg_i,
    input  logic                      east_in_valid_i,
    output logic                      east_in_ready_o,
    output nx_pkg::nx_msg_t           east_out_msg_o,
    output logic                      east_out_valid_o,
    input  logic                      east_out_ready_i,
    input  logic                      east_out_present_i,
    // South
    input  nx_pkg::nx_msg_t           south_in_msg_i,
    input  logic                      south_in_valid_i,
    output logic                      south_in_ready_o,
    output nx_pkg::nx_msg_t           south_out_msg_o,
    output logic                      south_out_valid_o,
    input  logic                      south_out_ready_i,
    input  logic                      south_out_present_i,
    // West
    input  nx_pkg::nx_msg_t           west_in_msg_i,
    input  logic                      west_in_valid_i,
    output logic                      west_in_ready_o,
    output nx_pkg::nx_msg_t           west_out_msg_o,
    output logic                      west_out_valid_o,
    input  logic                      west_out_ready_i,
    input  logic                      west_out_present_i,
    // Local delivery
    output nx_pkg::nx_msg_t           local_msg_o,
    output logic                      local_valid_o,
    input  logic                      local_ready_i
);

    import nx_pkg::*;

    // Buffered inbound streams, indexed by direction
    nx_msg_t [3:0] skid_msg;
    logic [3:0]    skid_valid;
    logic [3:0]    skid_ready;

    // Single granted stream
    nx_msg_t grant_msg;
    logic    grant_valid;
    logic    grant_ready;

    // Decoder to distributor
    nx_msg_t dist_msg;
    nx_dir_t dist_dir;
    logic    dist_valid;
    logic    dist_ready;

    // One skid buffer per neighbour
    nx_stream_skid u_skid_north (
        .clk_i, .rst_i,
        .in_msg_i   (north_in_msg_i),   .in_valid_i (north_in_valid_i),
        .in_ready_o (north_in_ready_o), .out_msg_o  (skid_msg[DIRX_NORTH]),
        .out_valid_o(skid_valid[DIRX_NORTH]), .out_ready_i(skid_ready[DIRX_NORTH])
    );
    nx_stream_skid u_skid_east (
        .clk_i, .rst_i,
        .in_msg_i   (east_in_msg_i),   .in_valid_i (east_in_valid_i),
        .in_ready_o (east_in_ready_o), .out_msg_o  (skid_msg[DIRX_EAST]),
        .out_valid_o(skid_valid[DIRX_EAST]), .out_ready_i(skid_ready[DIRX_EAST])
    );
    nx_stream_skid u_skid_south (
        .clk_i, .rst_i,
        .in_msg_i   (south_in_msg_i),   .in_valid_i (south_in_valid_i),
        .in_ready_o (south_in_ready_o), .out_msg_o  (skid_msg[DIRX_SOUTH]),
        .out_valid_o(skid_valid[DIRX_SOUTH]), .out_ready_i(skid_ready[DIRX_SOUTH])
    );
    nx_stream_skid u_skid_west (
        .clk_i, .rst_i,
        .in_msg_i   (west_in_msg_i),   .in_valid_i (west_in_valid_i),
        .in_ready_o (west_in_ready_o), .out_msg_o  (skid_msg[DIRX_WEST]),
        .out_valid_o(skid_valid[DIRX_WEST]), .out_ready_i(skid_ready[DIRX_WEST])
    );

    // One inbound stream routed per cycle
    nx_stream_arbiter u_arbiter (
        .clk_i, .rst_i,
        .req_msg_i  (skid_msg),  .req_valid_i  (skid_valid), .req_ready_o  (skid_ready),
        .grant_msg_o(grant_msg), .grant_valid_o(grant_valid), .grant_ready_i(grant_ready)
    );

    nx_msg_decoder u_decoder (
        .node_row_i, .node_col_i,
        .msg_i       (grant_msg), .msg_valid_i(grant_valid), .msg_ready_o(grant_ready),
        .local_msg_o, .local_valid_o, .local_ready_i,
        .dist_msg_o  (dist_msg),  .dist_dir_o (dist_dir),
        .dist_valid_o(dist_valid), .dist_ready_i(dist_ready)
    );

    // Neighbour presence feeds only the distributor
    nx_stream_distributor u_distributor (
        .clk_i, .rst_i,
        .dist_data_i    (dist_msg),   .dist_dir_i     (dist_dir),
        .dist_valid_i   (dist_valid), .dist_ready_o   (dist_ready),
        .north_data_o   (north_out_msg_o),   .north_valid_o  (north_out_valid_o),
        .north_ready_i  (north_out_ready_i), .north_present_i(north_out_present_i),
        .east_data_o    (east_out_msg_o),    .east_valid_o   (east_out_valid_o),
        .east_ready_i   (east_out_ready_i),  .east_present_i (east_out_present_i),
        .south_data_o   (south_out_msg_o),   .south_valid_o  (south_out_valid_o),
        .south_ready_i  (south_out_ready_i), .south_present_i(south_out_present_i),
        .west_data_o    (west_out_msg_o),    .west_valid_o   (west_out_valid_o),
        .west_ready_i   (west_out_ready_i),  .west_present_i (west_out_present_i)
    );

endmodule : nx_node_router

/* nx_router_tb.sv */
////////////////////////////////////////
// Mesh node router testbench
// Table-driven stimulus with a scoreboard per inbound and outbound pair
////////////////////////////////////////

`timescale 1ns/1ps

`include "nx_defs.svh"

module nx_router_tb;

    import nx_pkg::*;

    // One stimulus row
    // Rows sharing a batch are sent together
    typedef struct packed {
        logic [4:0]                   batch;
        logic [1:0]                   in_port;
        logic [`NX_ADDR_WIDTH-1:0]    row;
        logic [`NX_ADDR_WIDTH-1:0]    col;
        nx_cmd_t                      cmd;
        logic [`NX_PAYLOAD_WIDTH-1:0] payload;
        logic [3:0]                   present;
        logic                         stall;
        logic [2:0]                   exp_port;
    } vec_t;

    localparam int NUM_VECS        = 33;
    localparam int WATCHDOG_CYCLES = NUM_VECS * 20 + 200;
    localparam int NODE_ROW        = 2;
    localparam int NODE_COL        = 2;

    // Ports 0..3 follow nx_dir_t
    // Port 4 is local delivery
    localparam vec_t VECS [NUM_VECS] = '{
        // Eight off-node targets sent one message at a time
        '{5'd0,  2'd0, 4'd1, 4'd1, NX_CMD_LOAD,   22'h000001, 4'hF, 1'b0, 3'd0},
        '{5'd1,  2'd1, 4'd1, 4'd2, NX_CMD_STORE,  22'h010002, 4'hF, 1'b0, 3'd0},
        '{5'd2,  2'd2, 4'd1, 4'd3, NX_CMD_SIGNAL, 22'h020003, 4'hF, 1'b0, 3'd0},
        '{5'd3,  2'd3, 4'd2, 4'd1, NX_CMD_OUTPUT, 22'h030004, 4'hF, 1'b0, 3'd3},
        '{5'd4,  2'd0, 4'd2, 4'd3, NX_CMD_LOAD,   22'h040005, 4'hF, 1'b0, 3'd1},
        '{5'd5,  2'd1, 4'd3, 4'd1, NX_CMD_STORE,  22'h050006, 4'hF, 1'b0, 3'd2},
        '{5'd6,  2'd2, 4'd3, 4'd2, NX_CMD_SIGNAL, 22'h060007, 4'hF, 1'b0, 3'd2},
        '{5'd7,  2'd3, 4'd3, 4'd3, NX_CMD_OUTPUT, 22'h070008, 4'hF, 1'b0, 3'd2},
        // Own position with all payload bits set
        '{5'd8,  2'd1, 4'd2, 4'd2, NX_CMD_SIGNAL, 22'h3FFFFF, 4'hF, 1'b0, 3'd4},
        // Each row has one neighbour absent and deflects clockwise
        '{5'd9,  2'd2, 4'd1, 4'd2, NX_CMD_LOAD,   22'h090001, 4'hE, 1'b0, 3'd1},
        '{5'd10, 2'd3, 4'd2, 4'd3, NX_CMD_STORE,  22'h0A0001, 4'hD, 1'b0, 3'd2},
        '{5'd11, 2'd0, 4'd3, 4'd2, NX_CMD_SIGNAL, 22'h0B0001, 4'hB, 1'b0, 3'd3},
        '{5'd12, 2'd1, 4'd2, 4'd1, NX_CMD_OUTPUT, 22'h0C0001, 4'h7, 1'b0, 3'd0},
        // All four inbound ports at once
        '{5'd13, 2'd0, 4'd3, 4'd2, NX_CMD_LOAD,   22'h0D0001, 4'hF, 1'b0, 3'd2},
        '{5'd13, 2'd1, 4'd2, 4'd1, NX_CMD_STORE,  22'h0D1001, 4'hF, 1'b0, 3'd3},
        '{5'd13, 2'd2, 4'd1, 4'd3, NX_CMD_SIGNAL, 22'h0D2001, 4'hF, 1'b0, 3'd0},
        '{5'd13, 2'd3, 4'd2, 4'd3, NX_CMD_OUTPUT, 22'h0D3001, 4'hF, 1'b0, 3'd1},
        '{5'd13, 2'd0, 4'd2, 4'd3, NX_CMD_LOAD,   22'h0D0002, 4'hF, 1'b0, 3'd1},
        '{5'd13, 2'd1, 4'd1, 4'd1, NX_CMD_STORE,  22'h0D1002, 4'hF, 1'b0, 3'd0},
        '{5'd13, 2'd2, 4'd2, 4'd2, NX_CMD_SIGNAL, 22'h0D2002, 4'hF, 1'b0, 3'd4},
        '{5'd13, 2'd3, 4'd3, 4'd0, NX_CMD_OUTPUT, 22'h0D3002, 4'hF, 1'b0, 3'd2},
        // Bursts again with random ready drops on the outputs
        '{5'd14, 2'd0, 4'd3, 4'd3, NX_CMD_LOAD,   22'h0E0001, 4'hF, 1'b1, 3'd2},
        '{5'd14, 2'd1, 4'd2, 4'd0, NX_CMD_STORE,  22'h0E1001, 4'hF, 1'b1, 3'd3},
        '{5'd14, 2'd2, 4'd3, 4'd1, NX_CMD_SIGNAL, 22'h0E2001, 4'hF, 1'b1, 3'd2},
        '{5'd14, 2'd3, 4'd1, 4'd0, NX_CMD_OUTPUT, 22'h0E3001, 4'hF, 1'b1, 3'd0},
        '{5'd14, 2'd0, 4'd0, 4'd2, NX_CMD_LOAD,   22'h0E0002, 4'hF, 1'b1, 3'd0},
        '{5'd14, 2'd1, 4'd2, 4'd2, NX_CMD_STORE,  22'h0E1002, 4'hF, 1'b1, 3'd4},
        '{5'd14, 2'd2, 4'd2, 4'd4, NX_CMD_SIGNAL, 22'h0E2002, 4'hF, 1'b1, 3'd1},
        '{5'd14, 2'd3, 4'd4, 4'd2, NX_CMD_OUTPUT, 22'h0E3002, 4'hF, 1'b1, 3'd2},
        '{5'd14, 2'd0, 4'd2, 4'd2, NX_CMD_LOAD,   22'h0E0003, 4'hF, 1'b1, 3'd4},
        '{5'd14, 2'd1, 4'd5, 4'd5, NX_CMD_STORE,  22'h0E1003, 4'hF, 1'b1, 3'd2},
        '{5'd14, 2'd2, 4'd0, 4'd0, NX_CMD_SIGNAL, 22'h0E2003, 4'hF, 1'b1, 3'd0},
        '{5'd14, 2'd3, 4'd2, 4'd7, NX_CMD_OUTPUT, 22'h0E3003, 4'hF, 1'b1, 3'd1}
    };

    string port_name [5] = '{"north", "east", "south", "west", "local"};

    logic                      clk_i = 1'b0;
    logic                      rst_i;
    logic [`NX_ADDR_WIDTH-1:0] node_row;
    logic [`NX_ADDR_WIDTH-1:0] node_col;
    nx_msg_t                   in_msg    [4];
    logic                      in_valid  [4];
    logic                      in_ready  [4];
    nx_msg_t                   out_msg   [5];
    logic                      out_valid [5];
    logic                      out_ready [5];
    logic                      present   [4];

    // Scoreboard queues per inbound and outbound pair
    // Queue index is in*5+out
    nx_msg_t exp_mem  [20][64];
    int      exp_wr   [20];
    int      exp_rd   [20];
    nx_msg_t send_mem [4][64];
    int      send_cnt [4];
    int      pending  [4];
    int      occ      [4];
    int      gcnt     [4];
    int      acc_cyc  [4];
    int      cyc = 0;
    int      errors = 0;
    logic    stall_en = 1'b0;
    logic    single_mode = 1'b0;
    logic    fair_mode = 1'b0;

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    nx_node_router dut_i (
        .clk_i, .rst_i, .node_row_i(node_row), .node_col_i(node_col),
        .north_in_msg_i(in_msg[0]), .north_in_valid_i(in_valid[0]),
        .north_in_ready_o(in_ready[0]), .north_out_msg_o(out_msg[0]),
        .north_out_valid_o(out_valid[0]), .north_out_ready_i(out_ready[0]),
        .north_out_present_i(present[0]),
        .east_in_msg_i(in_msg[1]), .east_in_valid_i(in_valid[1]),
        .east_in_ready_o(in_ready[1]), .east_out_msg_o(out_msg[1]),
        .east_out_valid_o(out_valid[1]), .east_out_ready_i(out_ready[1]),
        .east_out_present_i(present[1]),
        .south_in_msg_i(in_msg[2]), .south_in_valid_i(in_valid[2]),
        .south_in_ready_o(in_ready[2]), .south_out_msg_o(out_msg[2]),
        .south_out_valid_o(out_valid[2]), .south_out_ready_i(out_ready[2]),
        .south_out_present_i(present[2]),
        .west_in_msg_i(in_msg[3]), .west_in_valid_i(in_valid[3]),
        .west_in_ready_o(in_ready[3]), .west_out_msg_o(out_msg[3]),
        .west_out_valid_o(out_valid[3]), .west_out_ready_i(out_ready[3]),
        .west_out_present_i(present[3]),
        .local_msg_o(out_msg[4]), .local_valid_o(out_valid[4]),
        .local_ready_i(out_ready[4])
    );

    task automatic check_val(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("ERROR %s: expected %h, actual %h", name, exp_val, act_val);
            errors++;
        end
    endtask

    // Row first, then column, then one step clockwise if absent
    function automatic int route_ref(input logic [3:0] row, input logic [3:0] col,
                                     input logic [3:0] pres);
        int d;
        if (row < NODE_ROW) begin
            d = 0;
        end else if (row > NODE_ROW) begin
            d = 2;
        end else if (col < NODE_COL) begin
            d = 3;
        end else if (col > NODE_COL) begin
            d = 1;
        end else begin
            return 4;
        end
        if (!pres[d]) d = (d + 1) % 4;
        return d;
    endfunction

    function automatic int pending_sum();
        return pending[0] + pending[1] + pending[2] + pending[3];
    endfunction

    task automatic schedule_row(input vec_t v);
        nx_msg_t m;
        int      port;
        int      idx;
        m.tgt_row = v.row;
        m.tgt_col = v.col;
        m.command = v.cmd;
        m.payload = v.payload;
        port = route_ref(v.row, v.col, v.present);
        check_val("route_ref_port", v.exp_port, port);
        idx = v.in_port * 5 + port;
        exp_mem[idx][exp_wr[idx]] = m;
        exp_wr[idx]++;
        send_mem[v.in_port][send_cnt[v.in_port]] = m;
        send_cnt[v.in_port]++;
        pending[v.in_port]++;
    endtask

    // Valid held with its message until the router takes it
    task automatic send_port(input int p);
        if (send_cnt[p] > 0) begin
            @(posedge clk_i);
            for (int k = 0; k < send_cnt[p]; k++) begin
                in_msg[p]   <= send_mem[p][k];
                in_valid[p] <= 1'b1;
                do @(posedge clk_i); while (!in_ready[p]);
                acc_cyc[p] = cyc;
            end
            in_valid[p] <= 1'b0;
        end
    endtask

    // Match against the head of each inbound queue for this output
    task automatic take_output(input int o);
        int   idx;
        int   hit;
        int   lo;
        int   hi;
        logic busy_all;
        hit = -1;
        for (int p = 0; p < 4; p++) begin
            idx = p * 5 + o;
            if (hit < 0 && exp_rd[idx] < exp_wr[idx]) begin
                if (exp_mem[idx][exp_rd[idx]] === out_msg[o]) hit = p;
            end
        end
        if (hit < 0) begin
            for (int p = 3; p >= 0; p--) begin
                if (exp_rd[p * 5 + o] < exp_wr[p * 5 + o]) hit = p;
            end
            if (hit < 0) begin
                $display("Unexpected message %h on the %s output", out_msg[o], port_name[o]);
                errors++;
                return;
            end
            idx = hit * 5 + o;
            check_val({port_name[o], "_out_msg"}, exp_mem[idx][exp_rd[idx]], out_msg[o]);
        end
        busy_all = (pending[0] > 0) && (pending[1] > 0) && (pending[2] > 0) && (pending[3] > 0);
        exp_rd[hit * 5 + o]++;
        pending[hit]--;
        occ[hit]--;
        if (single_mode) check_val("out_latency", acc_cyc[hit] + 1, cyc);
        // Grant spread only counted while all four ports still wait
        if (fair_mode && busy_all) begin
            gcnt[hit]++;
            lo = gcnt[0];
            hi = gcnt[0];
            for (int p = 1; p < 4; p++) begin
                if (gcnt[p] < lo) lo = gcnt[p];
                if (gcnt[p] > hi) hi = gcnt[p];
            end
            check_val("grant_spread_ok", 1, (hi - lo) <= 1);
        end
    endtask

    // Output monitor and skid occupancy model
    always @(posedge clk_i) begin
        if (!rst_i) begin
            for (int p = 0; p < 4; p++) begin
                check_val({port_name[p], "_in_ready"}, occ[p] < 2, in_ready[p]);
            end
            for (int p = 0; p < 4; p++) begin
                if (in_valid[p] && in_ready[p]) occ[p]++;
            end
            for (int o = 0; o < 5; o++) begin
                if (out_valid[o] && out_ready[o]) take_output(o);
            end
        end
    end

    // Random ready drops only in stall batches
    initial begin
        void'($urandom(56));
        for (int o = 0; o < 5; o++) out_ready[o] = 1'b1;
        forever begin
            @(posedge clk_i);
            for (int o = 0; o < 5; o++) begin
                if (stall_en) begin
                    out_ready[o] <= ($urandom % 4) != 0;
                end else begin
                    out_ready[o] <= 1'b1;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout: the router did not deliver all messages in %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int i;
        int j;
        rst_i    = 1'b1;
        node_row = NODE_ROW;
        node_col = NODE_COL;
        for (int p = 0; p < 4; p++) begin
            in_msg[p]   = '0;
            in_valid[p] = 1'b0;
            present[p]  = 1'b1;
            pending[p]  = 0;
            occ[p]      = 0;
            acc_cyc[p]  = 0;
        end
        for (int q = 0; q < 20; q++) begin
            exp_wr[q] = 0;
            exp_rd[q] = 0;
        end
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;

        // Idle state right after reset
        @(posedge clk_i);
        for (int o = 0; o < 5; o++) check_val({port_name[o], "_out_valid"}, 0, out_valid[o]);
        for (int p = 0; p < 4; p++) check_val({port_name[p], "_in_ready"}, 1, in_ready[p]);

        i = 0;
        while (i < NUM_VECS) begin
            j = i;
            while (j < NUM_VECS && VECS[j].batch == VECS[i].batch) j++;
            for (int p = 0; p < 4; p++) begin
                send_cnt[p] = 0;
                gcnt[p]     = 0;
            end
            for (int k = i; k < j; k++) schedule_row(VECS[k]);
            // Presence only changes while the router is idle
            @(posedge clk_i);
            for (int p = 0; p < 4; p++) present[p] <= VECS[i].present[p];
            stall_en    <= VECS[i].stall;
            single_mode <= (j - i == 1) && !VECS[i].stall;
            fair_mode   <= (j - i > 1) && !VECS[i].stall;
            fork
                send_port(0);
                send_port(1);
                send_port(2);
                send_port(3);
            join
            while (pending_sum() > 0) @(posedge clk_i);
            i = j;
        end

        repeat (2) @(posedge clk_i);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : nx_router_tb

/* compile.f */
+incdir+.
nx_pkg.sv
nx_stream_skid.sv
nx_stream_arbiter.sv
nx_msg_decoder.sv
nx_stream_distributor.sv
nx_node_router.sv
nx_router_tb.sv
